/* source/axil_stat_csr.sv */
`default_nettype none

// axi4-lite register block, one transaction in flight per direction
module axil_stat_csr (
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    // write address and data
    input  wire logic [3:0]                   awaddr,
    input  wire logic                         awvalid,
    output logic                              awready,
    input  wire logic [31:0]                  wdata,
    input  wire logic                         wvalid,
    output logic                              wready,

    // write response
    output logic      [1:0]                   bresp,
    output logic                              bvalid,
    input  wire logic                         bready,

    // read address and data
    input  wire logic [3:0]                   araddr,
    input  wire logic                         arvalid,
    output logic                              arready,
    output logic      [31:0]                  rdata,
    output logic      [1:0]                   rresp,
    output logic                              rvalid,
    input  wire logic                         rready,

    // monitor side
    output axis_stat_pkg::stat_ctrl_t         ctrl,
    input  wire axis_stat_pkg::stat_counts_t  counts
);

    import axis_stat_pkg::*;

    logic        wr_en;
    logic        rd_en;
    logic        wr_addr_ok;
    logic        drop_en;
    logic        clear;
    logic [31:0] rd_word;
    logic [1:0]  rd_resp;

    // address and data are taken in the same cycle
    assign wr_en   = awvalid && wvalid && !bvalid;
    assign awready = wr_en;
    assign wready  = wr_en;

    assign rd_en   = arvalid && !rvalid;
    assign arready = !rvalid;

    always_comb
    begin
        case (awaddr)
            csr_ctrl, csr_pkt_count, csr_drop_count, csr_last_sum:
                wr_addr_ok = 1'b1;
            default:
                wr_addr_ok = 1'b0;
        endcase
    end

    // drop_en is stored, clear is only a pulse
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            drop_en <= 1'b0;
            clear   <= 1'b0;
        end
        else
        begin
            clear <= 1'b0;
            if (wr_en && awaddr == csr_ctrl)
            begin
                drop_en <= wdata[0];
                clear   <= wdata[1];
            end
        end
    end

    assign ctrl.drop_en = drop_en;
    assign ctrl.clear   = clear;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            bvalid <= 1'b0;
        else if (wr_en)
            bvalid <= 1'b1;
        else if (bready)
            bvalid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            bresp <= wr_addr_ok ? resp_okay : resp_slverr;
    end

    // read mux, counters zero-extended
    always_comb
    begin
        rd_resp = resp_okay;
        case (araddr)
            csr_ctrl:       rd_word = {31'd0, drop_en};
            csr_pkt_count:  rd_word = {16'd0, counts.pkt_count};
            csr_drop_count: rd_word = {16'd0, counts.drop_count};
            csr_last_sum:   rd_word = {16'd0, counts.last_sum};
            default:
            begin
                rd_word = '0;
                rd_resp = resp_slverr;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rvalid <= 1'b0;
        else if (rd_en)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

/* source/axis_pkt_monitor.sv */
`default_nettype none

// packet monitor, combinational on the stream
// counts forwarded and dropped packets and keeps a half-word checksum
module axis_pkt_monitor (
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    input  wire axis_stat_pkg::axis_beat_t    s_beat,
    input  wire logic                         s_valid,
    output logic                              s_ready,

    output axis_stat_pkg::axis_beat_t         m_beat,
    output logic                              m_valid,
    input  wire logic                         m_ready,

    input  wire axis_stat_pkg::stat_ctrl_t    ctrl,
    output axis_stat_pkg::stat_counts_t       counts
);

    import axis_stat_pkg::*;

    logic        in_pkt;      // a packet has started and not ended
    logic        drop_hold;   // decision latched at the first beat
    logic        drop_cur;
    logic        xfer_in;
    logic        xfer_last;
    logic [15:0] beat_sum;
    logic [15:0] sum_acc;     // running checksum of earlier beats
    logic [15:0] pkt_sum;
    logic [15:0] pkt_count;
    logic [15:0] drop_count;
    logic [15:0] last_sum;

    // drop_en only matters on the first beat
    assign drop_cur = in_pkt ? drop_hold : ctrl.drop_en;

    assign m_beat  = s_beat;
    assign m_valid = s_valid && !drop_cur;
    assign s_ready = drop_cur || m_ready;  // sink dropped beats

    assign xfer_in   = s_valid && s_ready;
    assign xfer_last = xfer_in && s_beat.last;

    assign beat_sum = s_beat.data[31:16] + s_beat.data[15:0];
    assign pkt_sum  = sum_acc + beat_sum;  // includes the current beat

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_pkt    <= 1'b0;
            drop_hold <= 1'b0;
        end
        else if (xfer_in)
        begin
            in_pkt    <= !s_beat.last;
            drop_hold <= drop_cur;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sum_acc <= '0;
        else if (xfer_last)
            sum_acc <= '0;  // next packet starts fresh
        else if (xfer_in)
            sum_acc <= pkt_sum;
    end

    // clear wins over a packet ending on the same edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pkt_count  <= '0;
            drop_count <= '0;
            last_sum   <= '0;
        end
        else if (ctrl.clear)
        begin
            pkt_count  <= '0;
            drop_count <= '0;
            last_sum   <= '0;
        end
        else if (xfer_last)
        begin
            last_sum <= pkt_sum;
            if (drop_cur)
                drop_count <= drop_count + 16'd1;  // wraps
            else
                pkt_count <= pkt_count + 16'd1;
        end
    end

    always_comb
    begin
        counts            = '0;
        counts.pkt_count  = pkt_count;
        counts.drop_count = drop_count;
        counts.last_sum   = last_sum;
    end

endmodule

`default_nettype wire

/* source/axis_reg_slice_core.sv */
`default_nettype none

// valid/ready register slice
// forward register cuts valid and payload, backward register cuts ready
module axis_reg_slice_core #(
    parameter bit forward_registered = 1'b1,
    parameter bit back_registered    = 1'b1,
    parameter int payload_width      = 32
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,

    input  wire logic [payload_width-1:0] s_payload,
    input  wire logic                     s_valid,
    output logic                          s_ready,

    output logic      [payload_width-1:0] m_payload,
    output logic                          m_valid,
    input  wire logic                     m_ready
);

    generate
        if (!forward_registered && !back_registered)
        begin : g_pass
            // plain wires, no timing cut
            assign m_payload = s_payload;
            assign m_valid   = s_valid;
            assign s_ready   = m_ready;
        end
        else if (forward_registered && !back_registered)
        begin : g_fwd
            logic [payload_width-1:0] fwd_payload;
            logic                     fwd_valid;

            assign m_payload = fwd_payload;
            assign m_valid   = fwd_valid;
            assign s_ready   = !fwd_valid || m_ready;  // empty or draining

            always_ff @(posedge clk)
            begin
                if (!fwd_valid || m_ready)
                    fwd_payload <= s_payload;
            end

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    fwd_valid <= 1'b0;
                else if (s_valid)
                    fwd_valid <= 1'b1;
                else if (m_ready)
                    fwd_valid <= 1'b0;  // drained, nothing new
            end
        end
        else if (!forward_registered && back_registered)
        begin : g_bwd
            logic [payload_width-1:0] bwd_payload;  // spare beat
            logic                     bwd_ready;

            // spare beat goes out first once ready has dropped
            assign m_payload = bwd_ready ? s_payload : bwd_payload;
            assign m_valid   = !bwd_ready || s_valid;
            assign s_ready   = bwd_ready;

            always_ff @(posedge clk)
            begin
                if (bwd_ready)
                    bwd_payload <= s_payload;
            end

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    bwd_ready <= 1'b1;
                else if (m_ready)
                    bwd_ready <= 1'b1;
                else if (s_valid)
                    bwd_ready <= 1'b0;  // beat parked in the spare
            end
        end
        else
        begin : g_both
            logic [payload_width-1:0] fwd_payload;
            logic                     fwd_valid;
            logic                     fwd_ready;
            logic [payload_width-1:0] bwd_payload;
            logic [payload_width-1:0] mid_payload;
            logic                     mid_valid;
            logic                     bwd_ready;

            assign m_payload = fwd_payload;
            assign m_valid   = fwd_valid;
            assign s_ready   = bwd_ready;

            // joint between the skid stage and the forward stage
            assign fwd_ready   = !fwd_valid || m_ready;
            assign mid_payload = bwd_ready ? s_payload : bwd_payload;
            assign mid_valid   = !bwd_ready || s_valid;

            always_ff @(posedge clk)
            begin
                if (fwd_ready)
                    fwd_payload <= mid_payload;
            end

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    fwd_valid <= 1'b0;
                else if (mid_valid)
                    fwd_valid <= 1'b1;
                else if (m_ready)
                    fwd_valid <= 1'b0;
            end

            always_ff @(posedge clk)
            begin
                if (bwd_ready)
                    bwd_payload <= s_payload;
            end

            // ready drops one cycle after the forward stage stalls
            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    bwd_ready <= 1'b1;
                else if (fwd_ready)
                    bwd_ready <= 1'b1;
                else if (s_valid)
                    bwd_ready <= 1'b0;
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* source/axis_stat_pkg.sv */
`default_nettype none

package axis_stat_pkg;

    // one stream beat, no sideband
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } axis_beat_t;

    // control from the register block to the monitor
    typedef struct packed {
        logic drop_en;  // level
        logic clear;    // single-cycle pulse
    } stat_ctrl_t;

    // statistics from the monitor
    typedef struct packed {
        logic [15:0] pkt_count;   // packets forwarded
        logic [15:0] drop_count;  // packets dropped
        logic [15:0] last_sum;    // checksum of the latest packet
    } stat_counts_t;

    // register byte offsets
    localparam logic [3:0] csr_ctrl       = 4'h0;
    localparam logic [3:0] csr_pkt_count  = 4'h4;
    localparam logic [3:0] csr_drop_count = 4'h8;
    localparam logic [3:0] csr_last_sum   = 4'hc;

    // axi response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

/* source/axis_stat_top.sv */
`default_nettype none

// stream statistics path: in slice, monitor, out slice, plus csr block
module axis_stat_top #(
    parameter bit forward_registered = 1'b1,
    parameter bit back_registered    = 1'b1
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,

    input  wire axis_stat_pkg::axis_beat_t  s_axis_beat,
    input  wire logic                       s_axis_valid,
    output logic                            s_axis_ready,

    output axis_stat_pkg::axis_beat_t       m_axis_beat,
    output logic                            m_axis_valid,
    input  wire logic                       m_axis_ready,

    input  wire logic [3:0]                 awaddr,
    input  wire logic                       awvalid,
    output logic                            awready,
    input  wire logic [31:0]                wdata,
    input  wire logic                       wvalid,
    output logic                            wready,
    output logic      [1:0]                 bresp,
    output logic                            bvalid,
    input  wire logic                       bready,
    input  wire logic [3:0]                 araddr,
    input  wire logic                       arvalid,
    output logic                            arready,
    output logic      [31:0]                rdata,
    output logic      [1:0]                 rresp,
    output logic                            rvalid,
    input  wire logic                       rready
);

    import axis_stat_pkg::*;

    localparam int beat_w = $bits(axis_beat_t);

    logic [beat_w-1:0] mon_in_beat;   // in slice to monitor
    logic              mon_in_valid;
    logic              mon_in_ready;
    logic [beat_w-1:0] mon_out_beat;  // monitor to out slice
    logic              mon_out_valid;
    logic              mon_out_ready;
    stat_ctrl_t        ctrl;
    stat_counts_t      counts;

    axis_reg_slice_core #(
        .forward_registered (forward_registered),
        .back_registered    (back_registered),
        .payload_width      (beat_w)
    ) u_in_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_payload (s_axis_beat),
        .s_valid   (s_axis_valid),
        .s_ready   (s_axis_ready),
        .m_payload (mon_in_beat),
        .m_valid   (mon_in_valid),
        .m_ready   (mon_in_ready)
    );

    axis_pkt_monitor u_monitor (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_beat  (mon_in_beat),
        .s_valid (mon_in_valid),
        .s_ready (mon_in_ready),
        .m_beat  (mon_out_beat),
        .m_valid (mon_out_valid),
        .m_ready (mon_out_ready),
        .ctrl    (ctrl),
        .counts  (counts)
    );

    axis_reg_slice_core #(
        .forward_registered (forward_registered),
        .back_registered    (back_registered),
        .payload_width      (beat_w)
    ) u_out_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_payload (mon_out_beat),
        .s_valid   (mon_out_valid),
        .s_ready   (mon_out_ready),
        .m_payload (m_axis_beat),
        .m_valid   (m_axis_valid),
        .m_ready   (m_axis_ready)
    );

    axil_stat_csr u_csr (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .ctrl    (ctrl),
        .counts  (counts)
    );

endmodule

`default_nettype wire

/* tb.f */
source/axis_stat_pkg.sv
source/axis_reg_slice_core.sv
source/axis_pkt_monitor.sv
source/axil_stat_csr.sv
source/axis_stat_top.sv
verif/tb_axis_stat.sv

/* verif/tb_axis_stat.sv */
`default_nettype none

module tb_axis_stat;

    timeunit 1ns;
    timeprecision 1ps;

    import axis_stat_pkg::*;

    logic         clk;
    logic         rst_n;
    axis_beat_t   s_axis_beat;
    logic         s_axis_valid;
    logic         s_axis_ready;
    axis_beat_t   m_axis_beat;
    logic         m_axis_valid;
    logic         m_axis_ready;
    logic [3:0]   awaddr;
    logic         awvalid;
    logic         awready;
    logic [31:0]  wdata;
    logic         wvalid;
    logic         wready;
    logic [1:0]   bresp;
    logic         bvalid;
    logic         bready;
    logic [3:0]   araddr;
    logic         arvalid;
    logic         arready;
    logic [31:0]  rdata;
    logic [1:0]   rresp;
    logic         rvalid;
    logic         rready;

    axis_beat_t   exp_q[$];    // beats still owed by m_axis
    stat_counts_t exp_counts;
    logic [15:0]  ref_sum;     // checksum of the packet being sent
    logic [31:0]  lfsr = 32'hfcd5;
    int           cycle_cnt = 0;

    axis_stat_top u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= 4000)
        begin
            $display("timeout: run did not finish within 4000 cycles");
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic report_error(input string msg);
        $display("FAIL %0t %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // taps 32, 22, 2, 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], rand_bit()};
        return w;
    endfunction

    task automatic check_beat(input axis_beat_t got, input axis_beat_t exp);
        if (got !== exp)
            report_error($sformatf("beat data %h last %b, expected data %h last %b",
                                   got.data, got.last, exp.data, exp.last));
    endtask

    task automatic check_word(input string what, input logic [31:0] got_data,
                              input logic [1:0] got_resp, input logic [31:0] exp_data,
                              input logic [1:0] exp_resp);
        if (got_data !== exp_data || got_resp !== exp_resp)
            report_error($sformatf("%s: data %h resp %b, expected data %h resp %b",
                                   what, got_data, got_resp, exp_data, exp_resp));
    endtask

    // output side, one pop per m_axis transfer
    always @(posedge clk)
    begin
        if (rst_n && m_axis_valid && m_axis_ready)
        begin
            if (exp_q.size() == 0)
                report_error("m_axis produced a beat that was not expected");
            else
                check_beat(m_axis_beat, exp_q.pop_front());
        end
    end

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        do @(posedge clk); while (!awready);
        if (wready !== 1'b1)
            report_error("wready was not high together with awready");
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid)
            @(posedge clk);
        resp = bresp;
        @(posedge clk);  // handshake edge, bready is high
        #2;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        do @(posedge clk); while (!arready);
        #2;
        arvalid = 1'b0;
        while (!rvalid)
            @(posedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    // counts come from three register reads
    task automatic check_counts(input stat_counts_t exp);
        stat_counts_t got;
        logic [31:0]  data;
        logic [1:0]   resp;
        axil_read(csr_pkt_count, data, resp);
        check_word("pkt_count read", {16'd0, data[31:16]}, resp, 32'd0, resp_okay);
        got.pkt_count = data[15:0];
        axil_read(csr_drop_count, data, resp);
        check_word("drop_count read", {16'd0, data[31:16]}, resp, 32'd0, resp_okay);
        got.drop_count = data[15:0];
        axil_read(csr_last_sum, data, resp);
        check_word("last_sum read", {16'd0, data[31:16]}, resp, 32'd0, resp_okay);
        got.last_sum = data[15:0];
        if (got !== exp)
            report_error($sformatf("counts pkt %0d drop %0d sum %h, expected %0d %0d %h",
                                   got.pkt_count, got.drop_count, got.last_sum,
                                   exp.pkt_count, exp.drop_count, exp.last_sum));
    endtask

    task automatic send_beat(input logic [31:0] data, input logic last, input bit fwd);
        axis_beat_t beat;
        beat.data = data;
        beat.last = last;
        ref_sum = ref_sum + data[31:16] + data[15:0];
        if (fwd)
            exp_q.push_back(beat);
        s_axis_beat  = beat;
        s_axis_valid = 1'b1;
        do @(posedge clk); while (!s_axis_ready);
        #2;
        s_axis_valid = 1'b0;
    endtask

    task automatic send_packet(input int n_beats, input bit fwd);
        ref_sum = 16'd0;
        for (int i = 0; i < n_beats; i++)
            send_beat(rand_word(), i == n_beats - 1, fwd);
        if (fwd)
            exp_counts.pkt_count = exp_counts.pkt_count + 16'd1;
        else
            exp_counts.drop_count = exp_counts.drop_count + 16'd1;
        exp_counts.last_sum = ref_sum;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);  // dropped beats reach the monitor one cycle late
        #2;
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        logic [1:0]  resp;
        if (m_axis_valid !== 1'b0 || s_axis_ready !== 1'b1)
            report_error("stream handshake not in its reset state");
        axil_read(csr_ctrl, data, resp);
        check_word("ctrl after reset", data, resp, 32'd0, resp_okay);
        check_counts(exp_counts);
    endtask

    task automatic test_forwarding();
        send_packet(1, 1'b1);
        send_packet(4, 1'b1);
        send_packet(7, 1'b1);
        wait_drain();
        check_counts(exp_counts);
    endtask

    task automatic test_backpressure();
        logic [63:0] pattern;
        for (int i = 0; i < 64; i++)
            pattern[i] = rand_bit();
        fork
            send_packet(20, 1'b1);
            begin
                for (int i = 0; i < 64; i++)
                begin
                    @(posedge clk);
                    #2;
                    m_axis_ready = pattern[i];
                end
            end
        join
        m_axis_ready = 1'b1;
        wait_drain();
        check_counts(exp_counts);
    endtask

    task automatic test_drop_mode();
        logic [1:0] resp;
        axil_write(csr_ctrl, 32'h1, resp);
        check_word("ctrl write", 32'd0, resp, 32'd0, resp_okay);
        send_packet(3, 1'b0);
        send_packet(5, 1'b0);
        wait_drain();
        check_counts(exp_counts);
        // drop_en raised after the second beat, packet still forwarded
        axil_write(csr_ctrl, 32'h0, resp);
        ref_sum = 16'd0;
        send_beat(rand_word(), 1'b0, 1'b1);
        send_beat(rand_word(), 1'b0, 1'b1);
        axil_write(csr_ctrl, 32'h1, resp);
        send_beat(rand_word(), 1'b0, 1'b1);
        send_beat(rand_word(), 1'b1, 1'b1);
        exp_counts.pkt_count = exp_counts.pkt_count + 16'd1;
        exp_counts.last_sum  = ref_sum;
        wait_drain();
        check_counts(exp_counts);
    endtask

    task automatic test_clear();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_write(csr_ctrl, 32'h3, resp);  // keep drop_en, pulse clear
        check_word("clear write", 32'd0, resp, 32'd0, resp_okay);
        exp_counts = '0;
        check_counts(exp_counts);
        axil_read(csr_ctrl, data, resp);
        check_word("ctrl after clear", data, resp, 32'h1, resp_okay);
    endtask

    task automatic test_bad_address();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_write(4'h2, 32'h0, resp);
        check_word("write to unknown address", 32'd0, resp, 32'd0, resp_slverr);
        axil_read(4'h6, data, resp);
        check_word("read from unknown address", data, resp, 32'd0, resp_slverr);
        axil_write(csr_pkt_count, 32'hffff, resp);  // counters are read only
        check_word("write to pkt_count", 32'd0, resp, 32'd0, resp_okay);
        axil_read(csr_ctrl, data, resp);
        check_word("ctrl after bad access", data, resp, 32'h1, resp_okay);
        check_counts(exp_counts);
    endtask

    initial
    begin
        rst_n        = 1'b0;
        s_axis_beat  = '0;
        s_axis_valid = 1'b0;
        m_axis_ready = 1'b1;
        awaddr       = 4'h0;
        awvalid      = 1'b0;
        wdata        = 32'd0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = 4'h0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        exp_counts   = '0;
        ref_sum      = 16'd0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        test_forwarding();
        test_backpressure();
        test_drop_mode();
        test_clear();
        test_bad_address();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
